//--- build.f
+incdir+include
source/fv_mem_pkg.sv
source/fv_reg_pkg.sv
source/fv_bank_sram.sv
source/fv_bank_ctrl.sv
source/fv_mem_regs.sv
source/fv_mem_top.sv
verification/fv_mem_props.sv
verification/fv_mem_tb.sv

//--- include/fv_mem_cfg.svh
////////////////////////////////////////
// feature-vector memory configuration
////////////////////////////////////////
`ifndef FV_MEM_CFG_SVH
`define FV_MEM_CFG_SVH

// bank organization
`define FV_NUM_BANKS 4

// width of one stored feature vector
`define FV_WIDTH 32

// entries per bank
`define FV_DEPTH 64

// largest fv_num a replay region can hold
`define FV_NUM_MAX 16

// replay regions per bank, depth split evenly
`define REPLAY_ITER_MAX 4

// AXI4-Lite control bus
`define AXI_ADDR_W 8
`define AXI_DATA_W 32

`endif

//--- run_sim.sh
#!/bin/sh
# compile and run the banked fv memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module fv_mem_tb -o fv_mem_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

sim_out=$(./obj_dir/fv_mem_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "^=== PASS ===$"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

//--- source/fv_bank_ctrl.sv
////////////////////////////////////////
// bank controller, update writes and
// replay streaming with output queue
////////////////////////////////////////
`timescale 1ns/10ps

module fv_bank_ctrl (
    input  logic                  clk,
    input  logic                  reset,
    input  fv_mem_pkg::fv_cnt_t   fv_num,
    input  fv_mem_pkg::iter_t     replay_iter,
    input  logic                  start,
    input  logic                  wr_valid,
    input  fv_mem_pkg::fv_addr_t  wr_addr,
    input  fv_mem_pkg::fv_data_t  wr_data,
    output logic                  wr_ready,
    output logic                  sram_cen_n,
    output logic                  sram_wen_n,
    output fv_mem_pkg::fv_addr_t  sram_addr,
    output fv_mem_pkg::fv_data_t  sram_d,
    input  fv_mem_pkg::fv_data_t  sram_q,
    output logic                  out_valid,
    output fv_mem_pkg::fv_data_t  out_data,
    output logic                  out_last,
    input  logic                  out_ready,
    output logic                  available
);

    // bank role and latched region
    fv_mem_pkg::bank_state_e state_q;
    fv_mem_pkg::fv_addr_t    base_q;
    fv_mem_pkg::fv_cnt_t     cnt_q;
    fv_mem_pkg::fv_cnt_t     rd_idx_q;

    // read issued last cycle, data on sram_q now
    logic rd_pend_q;
    logic rd_last_q;

    // two-entry output queue
    fv_mem_pkg::fv_data_t q_data [2];
    logic [1:0]           q_last;
    logic                 q_wr_ptr;
    logic                 q_rd_ptr;
    logic [1:0]           q_count;

    logic       wr_fire;
    logic       rd_fire;
    logic       pop;
    logic       reads_left;
    logic [1:0] occupancy;

    // writes only land while idle
    assign available = (state_q == fv_mem_pkg::BANK_IDLE);
    assign wr_ready  = available;
    assign wr_fire   = wr_valid & available;

    // output side of the queue
    assign out_valid = (q_count != 2'd0);
    assign out_data  = q_data[q_rd_ptr];
    assign out_last  = out_valid & q_last[q_rd_ptr];
    assign pop       = out_valid & out_ready;

    // queued plus in flight, a word leaving now counts as gone
    assign occupancy  = q_count + {1'b0, rd_pend_q} - {1'b0, pop};
    assign reads_left = (rd_idx_q != cnt_q);
    assign rd_fire    = (state_q == fv_mem_pkg::BANK_STREAM) & reads_left
                        & (occupancy < 2'd2);

    // sram port, write has the port in idle, reads in stream
    assign sram_cen_n = ~(wr_fire | rd_fire);
    assign sram_wen_n = ~wr_fire;
    assign sram_addr  = wr_fire ? wr_addr : base_q + fv_mem_pkg::fv_addr_t'(rd_idx_q);
    assign sram_d     = wr_data;

    // role FSM and read sequencing
    always_ff @(posedge clk) begin
        if (reset) begin
            state_q   <= fv_mem_pkg::BANK_IDLE;
            base_q    <= '0;
            cnt_q     <= '0;
            rd_idx_q  <= '0;
            rd_pend_q <= 1'b0;
            rd_last_q <= 1'b0;
        end else begin
            rd_pend_q <= rd_fire;
            // last read of the region carries the flag along
            rd_last_q <= rd_fire & ((rd_idx_q + fv_mem_pkg::fv_cnt_t'(1)) == cnt_q);
            if (rd_fire) begin
                rd_idx_q <= rd_idx_q + fv_mem_pkg::fv_cnt_t'(1);
            end
            case (state_q)
                fv_mem_pkg::BANK_IDLE: begin
                    // empty region has nothing to stream
                    if (start && fv_num != '0) begin
                        state_q  <= fv_mem_pkg::BANK_STREAM;
                        base_q   <= fv_mem_pkg::fv_addr_t'(replay_iter)
                                    * fv_mem_pkg::fv_addr_t'(fv_num);
                        cnt_q    <= fv_num;
                        rd_idx_q <= '0;
                    end
                end
                fv_mem_pkg::BANK_STREAM: begin
                    // back to pong role once last word is taken
                    if (pop && out_last) begin
                        state_q <= fv_mem_pkg::BANK_IDLE;
                    end
                end
                default: state_q <= fv_mem_pkg::BANK_IDLE;
            endcase
        end
    end

    // queue pointers and fill level
    always_ff @(posedge clk) begin
        if (reset) begin
            q_wr_ptr <= 1'b0;
            q_rd_ptr <= 1'b0;
            q_count  <= 2'd0;
        end else begin
            if (rd_pend_q) begin
                q_wr_ptr <= ~q_wr_ptr;
            end
            if (pop) begin
                q_rd_ptr <= ~q_rd_ptr;
            end
            q_count <= occupancy;
        end
    end

    // queue payload, sram data captured as it returns
    always_ff @(posedge clk) begin
        if (rd_pend_q) begin
            q_data[q_wr_ptr] <= sram_q;
            q_last[q_wr_ptr] <= rd_last_q;
        end
    end

endmodule

//--- source/fv_bank_sram.sv
////////////////////////////////////////
// single-port bank SRAM model
////////////////////////////////////////
`timescale 1ns/10ps

module fv_bank_sram #(
    parameter int DEPTH = 64,
    parameter int WIDTH = 32
) (
    input  logic                     clk,
    input  logic                     cen_n,
    input  logic                     wen_n,
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  logic [WIDTH-1:0]         d,
    output logic [WIDTH-1:0]         q
);

    // storage array, contents undefined at power up
    logic [WIDTH-1:0] mem [DEPTH];

    // chip enabled access, write or registered read
    always_ff @(posedge clk) begin
        if (!cen_n) begin
            if (!wen_n) begin
                mem[addr] <= d;
            end else begin
                // read data lands one cycle later
                q <= mem[addr];
            end
        end
    end

endmodule

//--- source/fv_mem_pkg.sv
////////////////////////////////////////
// feature-vector memory datapath types
////////////////////////////////////////
`include "fv_mem_cfg.svh"

package fv_mem_pkg;

    // one feature vector word
    typedef logic [`FV_WIDTH-1:0] fv_data_t;

    // sram word address inside one bank
    typedef logic [$clog2(`FV_DEPTH)-1:0] fv_addr_t;

    // fv_num, must hold FV_NUM_MAX itself
    typedef logic [$clog2(`FV_NUM_MAX + 1)-1:0] fv_cnt_t;

    // replay iteration index
    typedef logic [$clog2(`REPLAY_ITER_MAX)-1:0] iter_t;

    // bank role
    // idle accepts update writes (pong)
    // stream replays one region out (ping)
    typedef enum logic {
        BANK_IDLE   = 1'b0,
        BANK_STREAM = 1'b1
    } bank_state_e;

endpackage

//--- source/fv_mem_regs.sv
////////////////////////////////////////
// AXI4-Lite control registers for the
// banked feature-vector memory
////////////////////////////////////////
`timescale 1ns/10ps
`include "fv_mem_cfg.svh"

module fv_mem_regs (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       awvalid,
    output logic                       awready,
    input  logic [`AXI_ADDR_W-1:0]     awaddr,
    input  logic                       wvalid,
    output logic                       wready,
    input  logic [`AXI_DATA_W-1:0]     wdata,
    input  logic [`AXI_DATA_W/8-1:0]   wstrb,
    output logic                       bvalid,
    input  logic                       bready,
    output logic [1:0]                 bresp,
    input  logic                       arvalid,
    output logic                       arready,
    input  logic [`AXI_ADDR_W-1:0]     araddr,
    output logic                       rvalid,
    input  logic                       rready,
    output logic [`AXI_DATA_W-1:0]     rdata,
    output logic [1:0]                 rresp,
    output fv_mem_pkg::fv_cnt_t        fv_num,
    output fv_mem_pkg::iter_t          replay_iter,
    output logic                       start,
    input  logic [`FV_NUM_BANKS-1:0]   bank_available
);

    logic                   all_avail;
    logic                   wr_fire;
    logic                   rd_fire;
    logic                   wr_mapped;
    logic [`AXI_DATA_W-1:0] rd_word;
    logic [1:0]             rd_resp;

    assign all_avail = &bank_available;

    // address and data accepted together, one response at a time
    assign wr_fire = awvalid & wvalid & ~bvalid;
    assign awready = wr_fire;
    assign wready  = wr_fire;

    // one outstanding read
    assign arready = arvalid & ~rvalid;
    assign rd_fire = arready;

    // write address decode
    always_comb begin
        case (awaddr)
            fv_reg_pkg::REG_CTRL,
            fv_reg_pkg::REG_FV_NUM,
            fv_reg_pkg::REG_REPLAY_ITER,
            fv_reg_pkg::REG_STATUS: wr_mapped = 1'b1;
            default:                wr_mapped = 1'b0;
        endcase
    end

    // read mux, unmapped reads give zero
    always_comb begin
        rd_word = '0;
        rd_resp = fv_reg_pkg::RESP_OKAY;
        case (araddr)
            fv_reg_pkg::REG_CTRL: ;
            fv_reg_pkg::REG_FV_NUM:
                rd_word[$bits(fv_mem_pkg::fv_cnt_t)-1:0] = fv_num;
            fv_reg_pkg::REG_REPLAY_ITER:
                rd_word[$bits(fv_mem_pkg::iter_t)-1:0] = replay_iter;
            fv_reg_pkg::REG_STATUS:
                rd_word[fv_reg_pkg::STATUS_AVAIL_BIT] = all_avail;
            default: rd_resp = fv_reg_pkg::RESP_SLVERR;
        endcase
    end

    // configuration, start pulse and write response
    always_ff @(posedge clk) begin
        if (reset) begin
            bvalid      <= 1'b0;
            start       <= 1'b0;
            fv_num      <= '0;
            replay_iter <= '0;
        end else begin
            start <= 1'b0;
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            if (wr_fire) begin
                bvalid <= 1'b1;
                // start dropped while any bank still streams
                if (awaddr == fv_reg_pkg::REG_CTRL) begin
                    start <= wdata[fv_reg_pkg::CTRL_START_BIT] & all_avail;
                end
                if (awaddr == fv_reg_pkg::REG_FV_NUM && wstrb[0]) begin
                    fv_num <= wdata[$bits(fv_mem_pkg::fv_cnt_t)-1:0];
                end
                if (awaddr == fv_reg_pkg::REG_REPLAY_ITER && wstrb[0]) begin
                    replay_iter <= wdata[$bits(fv_mem_pkg::iter_t)-1:0];
                end
            end
        end
    end

    // read response handshake
    always_ff @(posedge clk) begin
        if (reset) begin
            rvalid <= 1'b0;
        end else if (rd_fire) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    // response payloads
    always_ff @(posedge clk) begin
        if (wr_fire) begin
            bresp <= wr_mapped ? fv_reg_pkg::RESP_OKAY : fv_reg_pkg::RESP_SLVERR;
        end
        if (rd_fire) begin
            rdata <= rd_word;
            rresp <= rd_resp;
        end
    end

endmodule

//--- source/fv_mem_top.sv
////////////////////////////////////////
// banked feature-vector memory top
////////////////////////////////////////
`timescale 1ns/10ps
`include "fv_mem_cfg.svh"

module fv_mem_top (
    input  logic                                         clk,
    input  logic                                         reset,
    // AXI4-Lite control
    input  logic                                         awvalid,
    output logic                                         awready,
    input  logic [`AXI_ADDR_W-1:0]                       awaddr,
    input  logic                                         wvalid,
    output logic                                         wready,
    input  logic [`AXI_DATA_W-1:0]                       wdata,
    input  logic [`AXI_DATA_W/8-1:0]                     wstrb,
    output logic                                         bvalid,
    input  logic                                         bready,
    output logic [1:0]                                   bresp,
    input  logic                                         arvalid,
    output logic                                         arready,
    input  logic [`AXI_ADDR_W-1:0]                       araddr,
    output logic                                         rvalid,
    input  logic                                         rready,
    output logic [`AXI_DATA_W-1:0]                       rdata,
    output logic [1:0]                                   rresp,
    // update-side write ports, one per bank
    input  logic [`FV_NUM_BANKS-1:0]                     wr_valid,
    input  fv_mem_pkg::fv_addr_t [`FV_NUM_BANKS-1:0]     wr_addr,
    input  fv_mem_pkg::fv_data_t [`FV_NUM_BANKS-1:0]     wr_data,
    output logic [`FV_NUM_BANKS-1:0]                     wr_ready,
    // small-FV stream ports, one per bank
    output logic [`FV_NUM_BANKS-1:0]                     out_valid,
    output fv_mem_pkg::fv_data_t [`FV_NUM_BANKS-1:0]     out_data,
    output logic [`FV_NUM_BANKS-1:0]                     out_last,
    input  logic [`FV_NUM_BANKS-1:0]                     out_ready,
    output logic                                         available
);

    // shared configuration from the register block
    fv_mem_pkg::fv_cnt_t             fv_num;
    fv_mem_pkg::iter_t               replay_iter;
    logic                            start;
    logic [`FV_NUM_BANKS-1:0]        bank_available;

    // whole memory is free only when every bank is idle
    assign available = &bank_available;

    fv_mem_regs fv_mem_regs_i (
        .clk(clk),             .reset(reset),
        .awvalid(awvalid),     .awready(awready),     .awaddr(awaddr),
        .wvalid(wvalid),       .wready(wready),       .wdata(wdata),
        .wstrb(wstrb),         .bvalid(bvalid),       .bready(bready),
        .bresp(bresp),         .arvalid(arvalid),     .arready(arready),
        .araddr(araddr),       .rvalid(rvalid),       .rready(rready),
        .rdata(rdata),         .rresp(rresp),
        .fv_num(fv_num),       .replay_iter(replay_iter),
        .start(start),         .bank_available(bank_available)
    );

    // controller plus sram per bank
    for (genvar i = 0; i < `FV_NUM_BANKS; i++) begin : bank
        logic                 sram_cen_n;
        logic                 sram_wen_n;
        fv_mem_pkg::fv_addr_t sram_addr;
        fv_mem_pkg::fv_data_t sram_d;
        fv_mem_pkg::fv_data_t sram_q;

        fv_bank_ctrl fv_bank_ctrl_i (
            .clk(clk),               .reset(reset),
            .fv_num(fv_num),         .replay_iter(replay_iter),
            .start(start),
            .wr_valid(wr_valid[i]),  .wr_addr(wr_addr[i]),
            .wr_data(wr_data[i]),    .wr_ready(wr_ready[i]),
            .sram_cen_n(sram_cen_n), .sram_wen_n(sram_wen_n),
            .sram_addr(sram_addr),   .sram_d(sram_d),         .sram_q(sram_q),
            .out_valid(out_valid[i]), .out_data(out_data[i]),
            .out_last(out_last[i]),  .out_ready(out_ready[i]),
            .available(bank_available[i])
        );

        fv_bank_sram #(
            .DEPTH(`FV_DEPTH),
            .WIDTH(`FV_WIDTH)
        ) fv_bank_sram_i (
            .clk(clk),
            .cen_n(sram_cen_n),
            .wen_n(sram_wen_n),
            .addr(sram_addr),
            .d(sram_d),
            .q(sram_q)
        );
    end

endmodule

//--- source/fv_reg_pkg.sv
////////////////////////////////////////
// fv memory register map and AXI codes
////////////////////////////////////////
`include "fv_mem_cfg.svh"

package fv_reg_pkg;

    // register byte offsets
    typedef enum logic [`AXI_ADDR_W-1:0] {
        REG_CTRL        = 8'h00,
        REG_FV_NUM      = 8'h04,
        REG_REPLAY_ITER = 8'h08,
        REG_STATUS      = 8'h0C
    } reg_addr_e;

    // AXI response codes in use
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axi_resp_e;

    // CTRL, write one to start, reads as zero
    localparam int CTRL_START_BIT = 0;

    // STATUS, all banks available
    localparam int STATUS_AVAIL_BIT = 0;

endpackage

//--- verification/fv_mem_props.sv
////////////////////////////////////////
// bank controller stream and port checks
////////////////////////////////////////
`timescale 1ns/10ps

module fv_mem_props (
    input logic                 clk,
    input logic                 reset,
    input logic                 out_valid,
    input fv_mem_pkg::fv_data_t out_data,
    input logic                 out_last,
    input logic                 out_ready,
    input logic                 wr_ready,
    input logic                 available
);

    // stalled word stays put until taken
    hold_stable: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last))
        else $error("stalled stream word changed or vanished before out_ready");

    // write port shut while the bank offers stream words
    port_closed: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> !wr_ready && !available)
        else $error("write port open while a stream word is offered");

    // bank idle and drained right after the last word is taken
    last_reopens: assert property (@(posedge clk) disable iff (reset)
        out_valid && out_ready && out_last |=> available && !out_valid)
        else $error("bank not idle and empty after the last stream word");

endmodule

// one checker per bank controller
bind fv_bank_ctrl fv_mem_props fv_mem_props_i (
    .clk(clk),             .reset(reset),
    .out_valid(out_valid), .out_data(out_data),
    .out_last(out_last),   .out_ready(out_ready),
    .wr_ready(wr_ready),   .available(available)
);

//--- verification/fv_mem_tb.sv
////////////////////////////////////////
// testbench for the banked fv memory
////////////////////////////////////////
`timescale 1ns/10ps
`include "fv_mem_cfg.svh"

module fv_mem_tb;

    localparam int NB        = `FV_NUM_BANKS;
    localparam int NUM_TESTS = 7;

    typedef enum int {
        K_REGS,
        K_STREAM,
        K_BUSY,
        K_ERROR
    } kind_e;

    typedef struct {
        int    fv_num;
        int    iter;
        int    pct;
        kind_e kind;
    } row_t;

    // fv_num, replay_iter, out_ready percent, kind
    row_t tests [NUM_TESTS] = '{
        '{5,  2, 100, K_REGS},
        '{4,  0, 100, K_STREAM},
        '{16, 3, 100, K_STREAM},
        '{7,  1, 60,  K_STREAM},
        '{12, 2, 30,  K_STREAM},
        '{8,  1, 50,  K_BUSY},
        '{6,  3, 40,  K_ERROR}
    };

    logic                                     clk = 1'b0;
    logic                                     reset;
    logic                                     awvalid;
    logic                                     awready;
    logic [`AXI_ADDR_W-1:0]                   awaddr;
    logic                                     wvalid;
    logic                                     wready;
    logic [`AXI_DATA_W-1:0]                   wdata;
    logic [`AXI_DATA_W/8-1:0]                 wstrb;
    logic                                     bvalid;
    logic                                     bready;
    logic [1:0]                               bresp;
    logic                                     arvalid;
    logic                                     arready;
    logic [`AXI_ADDR_W-1:0]                   araddr;
    logic                                     rvalid;
    logic                                     rready;
    logic [`AXI_DATA_W-1:0]                   rdata;
    logic [1:0]                               rresp;
    logic [NB-1:0]                            wr_valid;
    fv_mem_pkg::fv_addr_t [NB-1:0]            wr_addr;
    fv_mem_pkg::fv_data_t [NB-1:0]            wr_data;
    logic [NB-1:0]                            wr_ready;
    logic [NB-1:0]                            out_valid;
    fv_mem_pkg::fv_data_t [NB-1:0]            out_data;
    logic [NB-1:0]                            out_last;
    logic [NB-1:0]                            out_ready;
    logic                                     available;

    // reference copy of every bank
    fv_mem_pkg::fv_data_t model [NB][`FV_DEPTH];

    // write held on bank 0 across a stream
    logic                 pend_wr = 1'b0;
    fv_mem_pkg::fv_addr_t pend_addr;
    fv_mem_pkg::fv_data_t pend_data;

    int errors      = 0;
    int cycles      = 0;
    int cycle_limit = 0;

    fv_mem_top fv_mem_top_i (.*);

    always #20 clk = ~clk;

    // run length guard
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, DUT stopped responding", cycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic check_eq(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        assert (got === exp) else begin
            $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic reg_write(input logic [7:0] addr, input logic [31:0] data,
                             input logic [1:0] exp_resp);
        step();
        awvalid = 1'b1;
        wvalid  = 1'b1;
        awaddr  = addr;
        wdata   = data;
        bready  = 1'b1;
        #10;
        while (!awready) begin
            @(posedge clk);
            #12;
        end
        // data channel accepted together with the address
        check_eq("wready", 32'(wready), 32'd1);
        // handshake on this edge
        step();
        awvalid = 1'b0;
        wvalid  = 1'b0;
        #10;
        while (!bvalid) begin
            @(posedge clk);
            #12;
        end
        check_eq("bresp", 32'(bresp), 32'(exp_resp));
        step();
        bready = 1'b0;
    endtask

    task automatic reg_read_check(input logic [7:0] addr, input logic [31:0] exp_data,
                                  input logic [1:0] exp_resp);
        step();
        arvalid = 1'b1;
        araddr  = addr;
        rready  = 1'b1;
        #10;
        while (!arready) begin
            @(posedge clk);
            #12;
        end
        step();
        arvalid = 1'b0;
        #10;
        while (!rvalid) begin
            @(posedge clk);
            #12;
        end
        check_eq("rdata", rdata, exp_data);
        check_eq("rresp", 32'(rresp), 32'(exp_resp));
        step();
        rready = 1'b0;
    endtask

    // random words into one region of every bank
    task automatic fill_region(input int fv_num, input int iter);
        int base;
        base = iter * fv_num;
        for (int i = 0; i < fv_num; i++) begin
            step();
            for (int b = 0; b < NB; b++) begin
                wr_valid[b] = 1'b1;
                wr_addr[b]  = fv_mem_pkg::fv_addr_t'(base + i);
                wr_data[b]  = $urandom;
                model[b][base + i] = wr_data[b];
            end
            #10;
            check_eq("wr_ready", 32'(wr_ready), 32'({NB{1'b1}}));
        end
        step();
        wr_valid = '0;
    endtask

    // receive and check one region from each bank
    task automatic run_stream(input int fv_num, input int iter, input int pct);
        int   got [NB];
        int   base;
        int   tail;
        logic commit;
        logic all_done;
        base   = iter * fv_num;
        tail   = 0;
        commit = 1'b0;
        foreach (got[b]) begin
            got[b] = 0;
        end
        while (tail < 6) begin
            step();
            for (int b = 0; b < NB; b++) begin
                out_ready[b] = (($urandom % 100) < pct);
            end
            if (commit) begin
                wr_valid[0] = 1'b0;
                pend_wr     = 1'b0;
                commit      = 1'b0;
            end
            #10;
            all_done = 1'b1;
            for (int b = 0; b < NB; b++) begin
                // mid stream the bank is closed to writes
                if (got[b] > 0 && got[b] < fv_num) begin
                    check_eq("wr_ready", 32'(wr_ready[b]), 32'd0);
                    check_eq("available", 32'(available), 32'd0);
                end
                if (got[b] == fv_num) begin
                    check_eq("out_valid", 32'(out_valid[b]), 32'd0);
                end else if (out_valid[b] && out_ready[b]) begin
                    check_eq("out_data", out_data[b], model[b][base + got[b]]);
                    check_eq("out_last", 32'(out_last[b]), 32'(got[b] == fv_num - 1));
                    got[b]++;
                end
                if (got[b] != fv_num) begin
                    all_done = 1'b0;
                end
            end
            if (pend_wr && wr_ready[0] && !commit) begin
                assert (got[0] == fv_num) else begin
                    $display("pending write on bank 0 accepted while it was streaming");
                    errors++;
                end
                model[0][pend_addr] = pend_data;
                commit = 1'b1;
            end
            if (all_done) begin
                tail++;
            end
        end
        step();
        out_ready = '0;
    endtask

    initial begin
        row_t t;
        int   err_start;
        int   failed;
        failed      = 0;
        void'($urandom(80996));
        cycle_limit = 500;
        foreach (tests[n]) begin
            cycle_limit += 4 * (tests[n].fv_num + 20) * NB;
        end
        reset     = 1'b1;
        awvalid   = 1'b0;
        awaddr    = '0;
        wvalid    = 1'b0;
        wdata     = '0;
        wstrb     = '1;
        bready    = 1'b0;
        arvalid   = 1'b0;
        araddr    = '0;
        rready    = 1'b0;
        wr_valid  = '0;
        wr_addr   = '0;
        wr_data   = '0;
        out_ready = '0;
        repeat (10) @(posedge clk);
        #2;
        reset = 1'b0;

        foreach (tests[n]) begin
            t         = tests[n];
            err_start = errors;
            if (t.kind == K_REGS) begin
                check_eq("available", 32'(available), 32'd1);
                check_eq("wr_ready", 32'(wr_ready), 32'({NB{1'b1}}));
                reg_read_check(fv_reg_pkg::REG_STATUS, 32'd1, fv_reg_pkg::RESP_OKAY);
                // upper bits random, only the field width survives
                reg_write(fv_reg_pkg::REG_FV_NUM, ($urandom & ~32'h1F) | 32'(t.fv_num),
                          fv_reg_pkg::RESP_OKAY);
                reg_write(fv_reg_pkg::REG_REPLAY_ITER, ($urandom & ~32'h3) | 32'(t.iter),
                          fv_reg_pkg::RESP_OKAY);
                reg_read_check(fv_reg_pkg::REG_FV_NUM, 32'(t.fv_num), fv_reg_pkg::RESP_OKAY);
                reg_read_check(fv_reg_pkg::REG_REPLAY_ITER, 32'(t.iter),
                               fv_reg_pkg::RESP_OKAY);
                reg_read_check(fv_reg_pkg::REG_CTRL, 32'd0, fv_reg_pkg::RESP_OKAY);
            end else begin
                reg_write(fv_reg_pkg::REG_FV_NUM, 32'(t.fv_num), fv_reg_pkg::RESP_OKAY);
                reg_write(fv_reg_pkg::REG_REPLAY_ITER, 32'(t.iter), fv_reg_pkg::RESP_OKAY);
                fill_region(t.fv_num, t.iter);
                if (t.kind == K_ERROR) begin
                    reg_write(8'h10, 32'hFFFF_FFFF, fv_reg_pkg::RESP_SLVERR);
                    reg_read_check(8'h20, 32'd0, fv_reg_pkg::RESP_SLVERR);
                    reg_read_check(fv_reg_pkg::REG_FV_NUM, 32'(t.fv_num),
                                   fv_reg_pkg::RESP_OKAY);
                    reg_read_check(fv_reg_pkg::REG_REPLAY_ITER, 32'(t.iter),
                                   fv_reg_pkg::RESP_OKAY);
                end
                reg_write(fv_reg_pkg::REG_CTRL, 32'd1, fv_reg_pkg::RESP_OKAY);
                // out_ready low, so every bank sits stalled and busy here
                if (t.kind == K_BUSY) begin
                    reg_read_check(fv_reg_pkg::REG_STATUS, 32'd0, fv_reg_pkg::RESP_OKAY);
                    pend_addr   = fv_mem_pkg::fv_addr_t'(t.fv_num * t.iter);
                    pend_data   = $urandom;
                    pend_wr     = 1'b1;
                    wr_valid[0] = 1'b1;
                    wr_addr[0]  = pend_addr;
                    wr_data[0]  = pend_data;
                end
                if (t.kind == K_ERROR) begin
                    reg_write(fv_reg_pkg::REG_CTRL, 32'd1, fv_reg_pkg::RESP_OKAY);
                end
                run_stream(t.fv_num, t.iter, t.pct);
                // second pass must show the late write
                if (t.kind == K_BUSY) begin
                    reg_write(fv_reg_pkg::REG_CTRL, 32'd1, fv_reg_pkg::RESP_OKAY);
                    run_stream(t.fv_num, t.iter, t.pct);
                end
            end
            if (errors == err_start) begin
                $display("test %0d %s fv_num=%0d iter=%0d ready=%0d%%: ok",
                         n, t.kind.name(), t.fv_num, t.iter, t.pct);
            end else begin
                failed++;
                $display("test %0d %s fv_num=%0d iter=%0d ready=%0d%%: FAILED",
                         n, t.kind.name(), t.fv_num, t.iter, t.pct);
            end
        end

        $display("summary: %0d tests, %0d failed, %0d errors", NUM_TESTS, failed, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
